/* logic/muldiv_defs.svh */
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// operand width of the HI/LO datapath
`define MD_WIDTH 32

// cycles a multiply holds stall before its done cycle
`define MD_MUL_CYCLES 3

// one restoring step per quotient bit
`define MD_DIV_ITERS `MD_WIDTH

`endif

/* logic/muldiv_pkg.sv */
package muldiv_pkg;

    // ops held on the op port by the pipeline
    typedef enum logic [3:0] {
        MD_NOP   = 4'd0,
        MD_MULT  = 4'd1,
        MD_MULTU = 4'd2,
        MD_MADD  = 4'd3,
        MD_MADDU = 4'd4,
        MD_MSUB  = 4'd5,
        MD_MSUBU = 4'd6,
        MD_DIV   = 4'd7,
        MD_DIVU  = 4'd8,
        MD_MTHI  = 4'd9,
        MD_MTLO  = 4'd10
    } muldiv_op_e;

    // how a finished result lands in HI/LO
    typedef enum logic [2:0] {
        HL_WRITE   = 3'd0,
        HL_ADD     = 3'd1,
        HL_SUB     = 3'd2,
        HL_HI_ONLY = 3'd3,
        HL_LO_ONLY = 3'd4
    } hilo_mode_e;

endpackage

/* logic/muldiv_result_if.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

// one finished result, controller to HI/LO
interface muldiv_result_if;
    logic                   wr;   // single-cycle write strobe
    muldiv_pkg::hilo_mode_e mode;
    logic [`MD_WIDTH-1:0]   hi;
    logic [`MD_WIDTH-1:0]   lo;

    modport src (
        output wr, mode, hi, lo
    );

    modport dst (
        input wr, mode, hi, lo
    );

endinterface

/* logic/mult_unit.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module mult_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     abort,
    input  logic                     signed_op,
    input  logic [`MD_WIDTH-1:0]     a,
    input  logic [`MD_WIDTH-1:0]     b,
    output logic                     done,
    output logic [2*`MD_WIDTH-1:0]   product
);
    localparam int W  = `MD_WIDTH;
    localparam int CW = $clog2(`MD_MUL_CYCLES + 1);
    localparam logic [CW-1:0] LAST = CW'(`MD_MUL_CYCLES - 1);

    typedef enum logic [1:0] {IDLE, RUN, FIN} state_e;

    state_e         state;
    logic [CW-1:0]  cnt;
    logic [W-1:0]   mag_a;
    logic [W-1:0]   mag_b;
    logic [2*W-1:0] prod_q;   // unsigned magnitude product
    logic           neg_q;

    assign mag_a = (signed_op && a[W-1]) ? -a : a;
    assign mag_b = (signed_op && b[W-1]) ? -b : b;

    // product captured on the start edge, operands are held by the pipeline
    always_ff @(posedge clk) begin
        if (start) begin
            prod_q <= {{W{1'b0}}, mag_a} * {{W{1'b0}}, mag_b};
            neg_q  <= signed_op && (a[W-1] ^ b[W-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= RUN;
                    cnt   <= CW'(1);   // start cycle counts as the first
                end
                RUN: if (cnt == LAST) state <= FIN;
                     else cnt <= cnt + 1'b1;
                FIN: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign done    = (state == FIN);
    assign product = neg_q ? -prod_q : prod_q;   // sign fix on the way out

endmodule

/* logic/div_unit.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 abort,
    input  logic                 signed_op,
    input  logic [`MD_WIDTH-1:0] dividend,
    input  logic [`MD_WIDTH-1:0] divisor,
    output logic                 busy,
    output logic                 done,
    output logic [`MD_WIDTH-1:0] quotient,
    output logic [`MD_WIDTH-1:0] remainder
);
    localparam int W  = `MD_WIDTH;
    localparam int CW = $clog2(`MD_DIV_ITERS);
    localparam logic [CW-1:0] LAST = CW'(`MD_DIV_ITERS - 1);

    typedef enum logic [1:0] {IDLE, RUN, FIX} state_e;

    state_e        state;
    logic [CW-1:0] iter;
    logic [W-1:0]  rem_q;     // partial remainder
    logic [W-1:0]  quo_q;     // dividend bits shift out, quotient bits shift in
    logic [W-1:0]  dvsr_q;
    logic          neg_quo;
    logic          neg_rem;
    logic          div_zero;
    logic          dvd_neg;
    logic          dvs_neg;
    logic [W:0]    partial;
    logic [W:0]    diff;

    assign dvd_neg = signed_op && dividend[W-1];
    assign dvs_neg = signed_op && divisor[W-1];

    // trial subtract, top bit set means the divisor did not fit
    assign partial = {rem_q, quo_q[W-1]};
    assign diff    = partial - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state <= IDLE;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state <= RUN;
                    iter  <= '0;
                end
                RUN: begin
                    iter <= iter + 1'b1;
                    if (iter == LAST) state <= FIX;
                end
                FIX: begin
                    state <= IDLE;
                    done  <= 1'b1;   // results registered on this same edge
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            rem_q    <= '0;
            quo_q    <= dvd_neg ? -dividend : dividend;
            dvsr_q   <= dvs_neg ? -divisor : divisor;
            neg_quo  <= dvd_neg ^ dvs_neg;
            neg_rem  <= dvd_neg;   // remainder follows the dividend
            div_zero <= (divisor == '0);
        end else if (state == RUN) begin
            if (!diff[W]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= partial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end else if (state == FIX) begin
            // zero divisor leaves the dividend magnitude in rem_q
            quotient  <= div_zero ? '1 : (neg_quo ? -quo_q : quo_q);
            remainder <= neg_rem ? -rem_q : rem_q;
        end
    end

    assign busy = (state != IDLE);

endmodule

/* logic/muldiv_ctrl.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module muldiv_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  muldiv_pkg::muldiv_op_e op,
    input  logic [`MD_WIDTH-1:0]   a,
    input  logic [`MD_WIDTH-1:0]   b,
    input  logic                   flush,
    output logic                   stall,
    muldiv_result_if.src           res
);
    localparam int W = `MD_WIDTH;

    logic                   is_mul;
    logic                   is_div;
    logic                   is_mthi;
    logic                   is_mtlo;
    logic                   sign_op;
    muldiv_pkg::hilo_mode_e mode;
    logic                   busy_q;   // held op already started its unit
    logic                   mul_start;
    logic                   mul_done;
    logic [2*W-1:0]         product;
    logic                   div_start;
    logic                   div_busy;
    logic                   div_done;
    logic [W-1:0]           quotient;
    logic [W-1:0]           remainder;

    always_comb begin
        is_mul  = 1'b0;
        is_div  = 1'b0;
        is_mthi = 1'b0;
        is_mtlo = 1'b0;
        sign_op = 1'b0;
        mode    = muldiv_pkg::HL_WRITE;
        case (op)
            muldiv_pkg::MD_MULT:  begin is_mul = 1'b1; sign_op = 1'b1; end
            muldiv_pkg::MD_MULTU: is_mul = 1'b1;
            muldiv_pkg::MD_MADD:  begin is_mul = 1'b1; sign_op = 1'b1; mode = muldiv_pkg::HL_ADD; end
            muldiv_pkg::MD_MADDU: begin is_mul = 1'b1; mode = muldiv_pkg::HL_ADD; end
            muldiv_pkg::MD_MSUB:  begin is_mul = 1'b1; sign_op = 1'b1; mode = muldiv_pkg::HL_SUB; end
            muldiv_pkg::MD_MSUBU: begin is_mul = 1'b1; mode = muldiv_pkg::HL_SUB; end
            muldiv_pkg::MD_DIV:   begin is_div = 1'b1; sign_op = 1'b1; end
            muldiv_pkg::MD_DIVU:  is_div = 1'b1;
            muldiv_pkg::MD_MTHI:  begin is_mthi = 1'b1; mode = muldiv_pkg::HL_HI_ONLY; end
            muldiv_pkg::MD_MTLO:  begin is_mtlo = 1'b1; mode = muldiv_pkg::HL_LO_ONLY; end
            default: ;
        endcase
    end

    // one start per held op, never into a flush
    assign mul_start = is_mul && !busy_q && !flush;
    assign div_start = is_div && !busy_q && !div_busy && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush || mul_done || div_done) busy_q <= 1'b0;
        else if (mul_start || div_start) busy_q <= 1'b1;
    end

    // low again in the done cycle, which is where the op is consumed
    assign stall = (is_mul && !mul_done) || (is_div && !div_done);

    always_comb begin
        res.mode = mode;
        res.hi   = a;   // moves take the operand straight through
        res.lo   = a;
        if (mul_done) begin
            res.hi = product[2*W-1:W];
            res.lo = product[W-1:0];
            res.wr = is_mul;
        end else if (div_done) begin
            res.hi = remainder;
            res.lo = quotient;
            res.wr = is_div;
        end else begin
            res.wr = is_mthi || is_mtlo;
        end
        if (flush) res.wr = 1'b0;   // aborted op never lands
    end

    mult_unit u_mult (
        .clk       (clk),
        .rst       (rst),
        .start     (mul_start),
        .abort     (flush),
        .signed_op (sign_op),
        .a         (a),
        .b         (b),
        .done      (mul_done),
        .product   (product)
    );

    div_unit u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .abort     (flush),
        .signed_op (sign_op),
        .dividend  (a),
        .divisor   (b),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

/* logic/hilo_regs.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module hilo_regs (
    input  logic                 clk,
    input  logic                 rst,
    muldiv_result_if.dst         res,
    output logic [`MD_WIDTH-1:0] hi,
    output logic [`MD_WIDTH-1:0] lo
);
    localparam int W = `MD_WIDTH;

    logic [2*W-1:0] acc;
    logic [2*W-1:0] sum;
    logic [2*W-1:0] dif;

    // full 64-bit math so the carry crosses from LO into HI
    assign acc = {hi, lo};
    assign sum = acc + {res.hi, res.lo};
    assign dif = acc - {res.hi, res.lo};

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (res.wr) begin
            case (res.mode)
                muldiv_pkg::HL_WRITE: begin
                    hi <= res.hi;
                    lo <= res.lo;
                end
                muldiv_pkg::HL_ADD:     {hi, lo} <= sum;   // madd
                muldiv_pkg::HL_SUB:     {hi, lo} <= dif;   // msub
                muldiv_pkg::HL_HI_ONLY: hi <= res.hi;
                muldiv_pkg::HL_LO_ONLY: lo <= res.lo;
                default: ;
            endcase
        end
    end

endmodule

/* logic/muldiv_top.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module muldiv_top (
    input  logic                   clk,
    input  logic                   rst,
    input  muldiv_pkg::muldiv_op_e op,
    input  logic [`MD_WIDTH-1:0]   a,
    input  logic [`MD_WIDTH-1:0]   b,
    input  logic                   flush,
    output logic                   stall,
    output logic [`MD_WIDTH-1:0]   hi,
    output logic [`MD_WIDTH-1:0]   lo
);

    // finished results from the controller into HI/LO
    muldiv_result_if res_if ();

    muldiv_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .op    (op),
        .a     (a),
        .b     (b),
        .flush (flush),
        .stall (stall),
        .res   (res_if.src)
    );

    hilo_regs u_hilo (
        .clk (clk),
        .rst (rst),
        .res (res_if.dst),
        .hi  (hi),
        .lo  (lo)
    );

endmodule

/* dv/muldiv_assert.sv */
`timescale 1ns/1ns

module muldiv_assert (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic mul_done,
    input logic div_done,
    input logic wr
);

    // op port is NOP through reset
    a_stall_reset: assert property (@(posedge clk) rst |=> !stall)
        else $error("stall high in the cycle after reset");

    a_mul_pulse: assert property (@(posedge clk) disable iff (rst) mul_done |=> !mul_done)
        else $error("multiply done held longer than one cycle");

    a_div_pulse: assert property (@(posedge clk) disable iff (rst) div_done |=> !div_done)
        else $error("divide done held longer than one cycle");

    // pipeline kills the op along with the flush
    a_flush_wr: assert property (@(posedge clk) disable iff (rst) flush |=> !wr)
        else $error("HI/LO write in the cycle after a flush");

endmodule

bind muldiv_ctrl muldiv_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .flush    (flush),
    .mul_done (mul_done),
    .div_done (div_done),
    .wr       (res.wr)
);

/* dv/muldiv_tb.sv */
`timescale 1ns/1ns
`include "muldiv_defs.svh"

module muldiv_tb;
    localparam int CLK_PERIOD = 8;
    localparam int N_RAND = 6;
    localparam int N_OPS = 50 + 16 * N_RAND;
    localparam int TIMEOUT_CYCLES = N_OPS * (`MD_DIV_ITERS + 2 + 4) + 10;
    localparam logic [31:0] CORNERS [4] = '{32'h8000_0000, 32'hffff_ffff,
                                            32'h7fff_ffff, 32'h0000_0003};
    localparam muldiv_pkg::muldiv_op_e ACC_OPS [4] = '{muldiv_pkg::MD_MADD,
        muldiv_pkg::MD_MADDU, muldiv_pkg::MD_MSUB, muldiv_pkg::MD_MSUBU};

    logic                   clk;
    logic                   rst;
    muldiv_pkg::muldiv_op_e op;
    logic [`MD_WIDTH-1:0]   a;
    logic [`MD_WIDTH-1:0]   b;
    logic                   flush;
    logic                   stall;
    logic [`MD_WIDTH-1:0]   hi;
    logic [`MD_WIDTH-1:0]   lo;
    logic [31:0]            lfsr_state;
    logic [63:0]            model_hilo;   // HI:LO as the reference sees it
    logic [63:0]            exp_q [$];

    muldiv_top UUT (
        .clk   (clk),
        .rst   (rst),
        .op    (op),
        .a     (a),
        .b     (b),
        .flush (flush),
        .stall (stall),
        .hi    (hi),
        .lo    (lo)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] ref_hilo(input logic [63:0] prev,
            input muldiv_pkg::muldiv_op_e o, input logic [31:0] x, input logic [31:0] y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic [63:0]        sprod;
        logic [63:0]        uprod;
        sx = {{32{x[31]}}, x};
        sy = {{32{y[31]}}, y};
        sprod = sx * sy;
        uprod = {32'd0, x} * {32'd0, y};
        sq = (y == '0) ? 64'sd0 : sx / sy;   // 64-bit so min / -1 cannot overflow
        sr = (y == '0) ? 64'sd0 : sx % sy;
        case (o)
            muldiv_pkg::MD_MULT:  return sprod;
            muldiv_pkg::MD_MULTU: return uprod;
            muldiv_pkg::MD_MADD:  return prev + sprod;
            muldiv_pkg::MD_MADDU: return prev + uprod;
            muldiv_pkg::MD_MSUB:  return prev - sprod;
            muldiv_pkg::MD_MSUBU: return prev - uprod;
            muldiv_pkg::MD_DIV:   return (y == '0) ? {x, 32'hffff_ffff} : {sr[31:0], sq[31:0]};
            muldiv_pkg::MD_DIVU:  return (y == '0) ? {x, 32'hffff_ffff} : {x % y, x / y};
            muldiv_pkg::MD_MTHI:  return {x, prev[31:0]};
            muldiv_pkg::MD_MTLO:  return {prev[63:32], x};
            default:              return prev;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    // present one op, hold it while stalled, then drop back to NOP
    task automatic run_op(input muldiv_pkg::muldiv_op_e o, input logic [31:0] x,
            input logic [31:0] y);
        int cycles;
        cycles = 0;
        model_hilo = ref_hilo(model_hilo, o, x, y);
        @(posedge clk);
        op <= o;
        a  <= x;
        b  <= y;
        exp_q.push_back(model_hilo);
        @(negedge clk);
        while (stall) begin
            cycles++;
            @(negedge clk);
        end
        if (o inside {muldiv_pkg::MD_MULT, muldiv_pkg::MD_MULTU, muldiv_pkg::MD_MADD,
                muldiv_pkg::MD_MADDU, muldiv_pkg::MD_MSUB, muldiv_pkg::MD_MSUBU})
            check_eq("stall cycles", 64'(cycles), 64'(`MD_MUL_CYCLES));
        else if (o inside {muldiv_pkg::MD_MTHI, muldiv_pkg::MD_MTLO})
            check_eq("stall cycles", 64'(cycles), '0);
        @(posedge clk);
        op <= muldiv_pkg::MD_NOP;
    endtask

    // start an op, flush it after hold cycles; HI/LO must not move
    task automatic flush_op(input muldiv_pkg::muldiv_op_e o, input logic [31:0] x,
            input logic [31:0] y, input int hold);
        @(posedge clk);
        op <= o;
        a  <= x;
        b  <= y;
        repeat (hold) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        op    <= muldiv_pkg::MD_NOP;
        @(negedge clk);
        check_eq("stall", 64'(stall), '0);
        check_eq("hi", 64'(hi), 64'(model_hilo[63:32]));
        check_eq("lo", 64'(lo), 64'(model_hilo[31:0]));
    endtask

    // compare HI/LO one cycle after each consumed op
    initial begin
        logic [63:0] want;
        forever begin
            @(negedge clk);
            if (!rst && op != muldiv_pkg::MD_NOP && !stall && !flush) begin
                if (exp_q.size() == 0) begin
                    $display("an op completed that the testbench never issued");
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected completion");
                end
                want = exp_q.pop_front();
                @(negedge clk);
                check_eq("hi", 64'(hi), 64'(want[63:32]));
                check_eq("lo", 64'(lo), 64'(want[31:0]));
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst        = 1'b1;
        op         = muldiv_pkg::MD_NOP;
        a          = '0;
        b          = '0;
        flush      = 1'b0;
        lfsr_state = 32'd50;
        model_hilo = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        run_op(muldiv_pkg::MD_MTHI, 32'h1234_5678, '0);
        run_op(muldiv_pkg::MD_MTLO, 32'h9abc_def0, '0);
        run_op(muldiv_pkg::MD_MTLO, 32'h0000_0001, '0);   // hi stays put
        run_op(muldiv_pkg::MD_MTHI, 32'hffff_ffff, '0);

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op(muldiv_pkg::MD_MULT, CORNERS[i], CORNERS[j]);
                run_op(muldiv_pkg::MD_MULTU, CORNERS[i], CORNERS[j]);
            end
        end
        for (int i = 0; i < N_RAND; i++) begin
            run_op(muldiv_pkg::MD_MULT, rand_bits(32), rand_bits(32));
            run_op(muldiv_pkg::MD_MULTU, rand_bits(32), rand_bits(32));
        end

        // carry into HI, then borrow out of it
        run_op(muldiv_pkg::MD_MTHI, 32'h0000_0000, '0);
        run_op(muldiv_pkg::MD_MTLO, 32'hffff_ffff, '0);
        run_op(muldiv_pkg::MD_MADDU, 32'h0000_0001, 32'h0000_0001);
        run_op(muldiv_pkg::MD_MTLO, 32'h0000_0000, '0);
        run_op(muldiv_pkg::MD_MSUBU, 32'h0000_0001, 32'h0000_0001);
        run_op(muldiv_pkg::MD_MSUB, 32'hffff_ffff, 32'h0000_0002);
        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < 4; k++) begin
                run_op(muldiv_pkg::MD_MTHI, rand_bits(32), '0);
                run_op(muldiv_pkg::MD_MTLO, rand_bits(32), '0);
                run_op(ACC_OPS[k], rand_bits(32), rand_bits(32));
            end
        end

        run_op(muldiv_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_op(muldiv_pkg::MD_DIV, 32'hffff_fff9, 32'h0000_0000);   // negative by zero
        run_op(muldiv_pkg::MD_DIVU, 32'h8765_4321, 32'h0000_0000);
        run_op(muldiv_pkg::MD_DIV, 32'hffff_fff9, 32'h0000_0002);   // -7 / 2
        for (int i = 0; i < N_RAND; i++) begin
            run_op(muldiv_pkg::MD_DIV, rand_bits(32), rand_bits(32) >> rand_bits(5));
            run_op(muldiv_pkg::MD_DIVU, rand_bits(32), rand_bits(32) >> rand_bits(5));
        end

        flush_op(muldiv_pkg::MD_DIV, 32'h0000_1000, 32'h0000_0007, 5);
        run_op(muldiv_pkg::MD_DIVU, 32'h0000_1000, 32'h0000_0005);   // stale result would differ
        flush_op(muldiv_pkg::MD_MULT, 32'h0001_0000, 32'h0001_0000, 1);
        run_op(muldiv_pkg::MD_MADD, 32'hffff_fffe, 32'h0000_0003);

        repeat (3) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d issued ops never completed", exp_q.size());
            $display("=== FAIL ===");
            $fatal(1, "results left unchecked");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+logic
logic/muldiv_pkg.sv
logic/muldiv_result_if.sv
logic/mult_unit.sv
logic/div_unit.sv
logic/muldiv_ctrl.sv
logic/hilo_regs.sv
logic/muldiv_top.sv
dv/muldiv_assert.sv
dv/muldiv_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove $(OBJ_DIR)"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
